// File: hw/udp_defines.svh
`ifndef UDP_DEFINES_SVH
`define UDP_DEFINES_SVH

// stream and register bus widths
`define UDP_BEAT_W          64
`define UDP_KEEP_W          8
`define UDP_AXIL_ADDR_W     6
`define UDP_AXIL_DATA_W     32

// frame geometry, last beat carries 7 valid bytes
`define UDP_FRAME_BYTES     87
`define UDP_FRAME_BEATS     11
`define UDP_LAST_KEEP       8'h7F
`define UDP_RESP_OKAY       2'b00

// cycles between frames at reset, 10M cycles
`define UDP_DEFAULT_PERIOD  32'd10_000_000

// register map, byte offsets
`define REG_SENT_COUNT      6'h00
`define REG_TIMER           6'h04
`define REG_IP_CHECKSUM     6'h08
`define REG_DST_MAC0        6'h0C
`define REG_DST_MAC1        6'h10
`define REG_DST_MAC2        6'h14
`define REG_DST_MAC3        6'h18
`define REG_DST_MAC4        6'h1C
`define REG_DST_MAC5        6'h20
`define REG_DST_IP          6'h24
`define REG_PERIOD          6'h28

// ethernet header
`define UDP_SRC_MAC         48'h00_1A_2B_3C_4D_5E
`define UDP_DEFAULT_DST_MAC 48'hFF_FF_FF_FF_FF_FF
`define UDP_ETHERTYPE       16'h0800

// ipv4 header words, big endian, checksum field sits after ttl/proto
`define IP_VER_IHL_TOS      16'h4500
`define IP_TOTAL_LEN        16'h0049
`define IP_IDENT            16'hE40F
`define IP_FLAGS_FRAG       16'h4000
`define IP_TTL_PROTO        16'hFF11
`define IP_SRC_ADDR         32'hC0_A8_04_01
`define UDP_DEFAULT_DST_IP  32'hE0_00_00_FB

// udp header: src port, dst port, length, checksum
`define UDP_HEADER          64'h14E9_14E9_0035_A5EB

// 45 payload bytes, first byte on the wire is the msb
`define UDP_PAYLOAD \
    360'h0000_0000_0002_0000_0000_0000_055F_6970_7073_045F_7463_7005_6C6F_6361_6C00_000C_0001_045F_6970_70C0_1200_0C00_01

`endif

// File: hw/udp_pkg.sv
`include "udp_defines.svh"

package udp_pkg;

    // one stream beat, frame byte 0 of the beat in bits 7:0
    typedef logic [`UDP_BEAT_W-1:0] beat_t;

    // byte enables of a beat
    typedef logic [`UDP_KEEP_W-1:0] keep_t;

    // beat number within a frame, 0..10
    typedef logic [3:0] beat_idx_t;

    // mac address, first byte on the wire in the msb
    typedef logic [47:0] mac_t;

    // ipv4 address, first byte on the wire in the msb
    typedef logic [31:0] ipv4_t;

    // ones' complement header checksum
    typedef logic [15:0] csum_t;

    // axi4-lite data word
    typedef logic [`UDP_AXIL_DATA_W-1:0] reg_word_t;

    // axi4-lite byte address
    typedef logic [`UDP_AXIL_ADDR_W-1:0] axil_addr_t;

endpackage

// File: hw/udp_axil_regs.sv
`timescale 1ns/100ps
`include "udp_defines.svh"

module udp_axil_regs import udp_pkg::*; (
    input  logic       s00_axi_aclk,
    input  logic       s00_axi_aresetn,
    // write address and data
    input  axil_addr_t s00_axi_awaddr,
    input  logic       s00_axi_awvalid,
    output logic       s00_axi_awready,
    input  reg_word_t  s00_axi_wdata,
    input  logic       s00_axi_wvalid,
    output logic       s00_axi_wready,
    // write response
    output logic [1:0] s00_axi_bresp,
    output logic       s00_axi_bvalid,
    input  logic       s00_axi_bready,
    // read address and data
    input  axil_addr_t s00_axi_araddr,
    input  logic       s00_axi_arvalid,
    output logic       s00_axi_arready,
    output reg_word_t  s00_axi_rdata,
    output logic [1:0] s00_axi_rresp,
    output logic       s00_axi_rvalid,
    input  logic       s00_axi_rready,
    // status from the datapath
    input  reg_word_t  timer,
    input  reg_word_t  sent_count,
    input  csum_t      ip_csum,
    // configuration to the datapath
    output mac_t       dst_mac,
    output ipv4_t      dst_ip,
    output reg_word_t  period,
    output logic       period_wr
);

    // destination mac, one byte per register, index 0 goes out first
    logic [7:0] mac_q [6];
    logic       wr_hs;
    logic       rd_hs;

    // a write completes when ready meets both valids
    assign wr_hs = s00_axi_awready && s00_axi_awvalid && s00_axi_wvalid;
    assign rd_hs = s00_axi_arready && s00_axi_arvalid;

    // timer restarts on the same edge the new period lands
    assign period_wr = wr_hs && (s00_axi_awaddr == `REG_PERIOD);

    assign s00_axi_wready = s00_axi_awready;
    assign s00_axi_bresp  = `UDP_RESP_OKAY;
    assign s00_axi_rresp  = `UDP_RESP_OKAY;

    assign dst_mac = {mac_q[0], mac_q[1], mac_q[2], mac_q[3], mac_q[4], mac_q[5]};

    // write channel, ready pulses for one cycle per accepted write
    always_ff @(posedge s00_axi_aclk or negedge s00_axi_aresetn) begin
        if (!s00_axi_aresetn) begin
            s00_axi_awready <= 1'b0;
            s00_axi_bvalid  <= 1'b0;
            for (int i = 0; i < 6; i++) begin
                mac_q[i] <= 8'hFF;
            end
            dst_ip <= `UDP_DEFAULT_DST_IP;
            period <= `UDP_DEFAULT_PERIOD;
        end else begin
            s00_axi_awready <= !s00_axi_awready && !s00_axi_bvalid &&
                               s00_axi_awvalid && s00_axi_wvalid;
            if (wr_hs) begin
                s00_axi_bvalid <= 1'b1;
                // read-only and unmapped offsets fall through
                case (s00_axi_awaddr)
                    `REG_DST_MAC0: mac_q[0] <= s00_axi_wdata[7:0];
                    `REG_DST_MAC1: mac_q[1] <= s00_axi_wdata[7:0];
                    `REG_DST_MAC2: mac_q[2] <= s00_axi_wdata[7:0];
                    `REG_DST_MAC3: mac_q[3] <= s00_axi_wdata[7:0];
                    `REG_DST_MAC4: mac_q[4] <= s00_axi_wdata[7:0];
                    `REG_DST_MAC5: mac_q[5] <= s00_axi_wdata[7:0];
                    `REG_DST_IP:   dst_ip   <= s00_axi_wdata;
                    `REG_PERIOD:   period   <= s00_axi_wdata;
                    default: ;
                endcase
            end else if (s00_axi_bvalid && s00_axi_bready) begin
                s00_axi_bvalid <= 1'b0;
            end
        end
    end

    // read channel control
    always_ff @(posedge s00_axi_aclk or negedge s00_axi_aresetn) begin
        if (!s00_axi_aresetn) begin
            s00_axi_arready <= 1'b0;
            s00_axi_rvalid  <= 1'b0;
        end else begin
            s00_axi_arready <= !s00_axi_arready && !s00_axi_rvalid && s00_axi_arvalid;
            if (rd_hs) begin
                s00_axi_rvalid <= 1'b1;
            end else if (s00_axi_rvalid && s00_axi_rready) begin
                s00_axi_rvalid <= 1'b0;
            end
        end
    end

    // read data mux, sampled when the address is taken
    always_ff @(posedge s00_axi_aclk) begin
        if (rd_hs) begin
            case (s00_axi_araddr)
                `REG_SENT_COUNT:  s00_axi_rdata <= sent_count;
                `REG_TIMER:       s00_axi_rdata <= timer;
                `REG_IP_CHECKSUM: s00_axi_rdata <= {16'h0000, ip_csum};
                `REG_DST_MAC0:    s00_axi_rdata <= {24'h0, mac_q[0]};
                `REG_DST_MAC1:    s00_axi_rdata <= {24'h0, mac_q[1]};
                `REG_DST_MAC2:    s00_axi_rdata <= {24'h0, mac_q[2]};
                `REG_DST_MAC3:    s00_axi_rdata <= {24'h0, mac_q[3]};
                `REG_DST_MAC4:    s00_axi_rdata <= {24'h0, mac_q[4]};
                `REG_DST_MAC5:    s00_axi_rdata <= {24'h0, mac_q[5]};
                `REG_DST_IP:      s00_axi_rdata <= dst_ip;
                `REG_PERIOD:      s00_axi_rdata <= period;
                default:          s00_axi_rdata <= '0;
            endcase
        end
    end

endmodule

// File: hw/udp_send_timer.sv
`timescale 1ns/100ps

module udp_send_timer import udp_pkg::*; (
    input  logic      s00_axi_aclk,
    input  logic      s00_axi_aresetn,
    input  reg_word_t period,
    input  logic      period_wr,
    output reg_word_t timer,
    output logic      send_pulse
);

    // pulse on the cycle the count reaches the period, so period+1 apart
    assign send_pulse = (timer == period);

    always_ff @(posedge s00_axi_aclk or negedge s00_axi_aresetn) begin
        if (!s00_axi_aresetn) begin
            timer <= '0;
        end else if (period_wr || send_pulse) begin
            // new period or wrap, start over
            timer <= '0;
        end else begin
            timer <= timer + 1'b1;
        end
    end

endmodule

// File: hw/ip_header_checksum.sv
`timescale 1ns/100ps
`include "udp_defines.svh"

module ip_header_checksum import udp_pkg::*; (
    input  ipv4_t dst_ip,
    output csum_t ip_csum
);

    localparam ipv4_t SRC_IP = `IP_SRC_ADDR;

    // ten big-endian header words
    logic [15:0] words [10];
    // ten 16-bit words need at most 4 carry bits
    logic [19:0] sum;
    logic [16:0] fold1;
    logic [15:0] fold2;

    always_comb begin
        words[0] = `IP_VER_IHL_TOS;
        words[1] = `IP_TOTAL_LEN;
        words[2] = `IP_IDENT;
        words[3] = `IP_FLAGS_FRAG;
        words[4] = `IP_TTL_PROTO;
        // the checksum field counts as zero
        words[5] = 16'h0000;
        words[6] = SRC_IP[31:16];
        words[7] = SRC_IP[15:0];
        words[8] = dst_ip[31:16];
        words[9] = dst_ip[15:0];
    end

    always_comb begin
        sum = '0;
        for (int i = 0; i < 10; i++) begin
            sum = sum + {4'h0, words[i]};
        end
        // end-around carry, second fold catches the carry of the first
        fold1 = {1'b0, sum[15:0]} + {13'h0, sum[19:16]};
        fold2 = fold1[15:0] + {15'h0, fold1[16]};
    end

    assign ip_csum = ~fold2;

endmodule

// File: hw/udp_frame_assembler.sv
`timescale 1ns/100ps
`include "udp_defines.svh"

module udp_frame_assembler import udp_pkg::*; (
    input  beat_idx_t beat_idx,
    input  mac_t      dst_mac,
    input  ipv4_t     dst_ip,
    input  csum_t     ip_csum,
    output beat_t     beat
);

    // whole frame padded to 11 full beats
    localparam int BEAT_BYTES = `UDP_KEEP_W;
    localparam int FRAME_W    = `UDP_FRAME_BEATS * `UDP_BEAT_W;
    localparam int PAD_W      = FRAME_W - 8 * `UDP_FRAME_BYTES;

    // frame byte 0 in the msb, so fields concatenate in wire order
    logic [FRAME_W-1:0] frame;

    assign frame = {
        // bytes 0..13, ethernet header
        dst_mac,
        `UDP_SRC_MAC,
        `UDP_ETHERTYPE,
        // bytes 14..33, ipv4 header
        `IP_VER_IHL_TOS,
        `IP_TOTAL_LEN,
        `IP_IDENT,
        `IP_FLAGS_FRAG,
        `IP_TTL_PROTO,
        // bytes 24..25, high byte first
        ip_csum,
        `IP_SRC_ADDR,
        dst_ip,
        // bytes 34..41
        `UDP_HEADER,
        // bytes 42..86
        `UDP_PAYLOAD,
        // unused byte 7 of the last beat
        {PAD_W{1'b0}}
    };

    // pick the eight bytes of the indexed beat
    // earliest byte lands in bits 7:0 of the beat
    always_comb begin
        beat = '0;
        if (int'(beat_idx) < `UDP_FRAME_BEATS) begin
            for (int k = 0; k < BEAT_BYTES; k++) begin
                beat[8*k +: 8] = frame[FRAME_W - 1 - 8 * (BEAT_BYTES * int'(beat_idx) + k) -: 8];
            end
        end
    end

endmodule

// File: hw/udp_stream_tx.sv
`timescale 1ns/100ps
`include "udp_defines.svh"

module udp_stream_tx import udp_pkg::*; (
    input  logic      s00_axi_aclk,
    input  logic      s00_axi_aresetn,
    input  logic      send_pulse,
    input  beat_t     beat,
    input  logic      m00_axis_tready,
    output beat_idx_t beat_idx,
    output logic      m00_axis_tvalid,
    output beat_t     m00_axis_tdata,
    output keep_t     m00_axis_tkeep,
    output logic      m00_axis_tlast,
    output reg_word_t sent_count
);

    localparam beat_idx_t LAST_IDX = beat_idx_t'(`UDP_FRAME_BEATS - 1);

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } tx_state_t;

    tx_state_t state;
    logic      xfer;
    logic      last_beat;

    assign xfer      = m00_axis_tvalid && m00_axis_tready;
    assign last_beat = (beat_idx == LAST_IDX);

    // beat index only moves on a transfer, so data holds under back-pressure
    assign m00_axis_tvalid = (state == ST_BUSY);
    assign m00_axis_tdata  = beat;
    assign m00_axis_tlast  = m00_axis_tvalid && last_beat;

    always_comb begin
        if (!m00_axis_tvalid) begin
            m00_axis_tkeep = '0;
        end else if (last_beat) begin
            m00_axis_tkeep = `UDP_LAST_KEEP;
        end else begin
            m00_axis_tkeep = '1;
        end
    end

    // a trigger while busy is dropped
    always_ff @(posedge s00_axi_aclk or negedge s00_axi_aresetn) begin
        if (!s00_axi_aresetn) begin
            state      <= ST_IDLE;
            beat_idx   <= '0;
            sent_count <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (send_pulse) begin
                        state    <= ST_BUSY;
                        beat_idx <= '0;
                    end
                end
                ST_BUSY: begin
                    if (xfer && last_beat) begin
                        state      <= ST_IDLE;
                        beat_idx   <= '0;
                        sent_count <= sent_count + 1'b1;
                    end else if (xfer) begin
                        beat_idx <= beat_idx + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: hw/udp_stream_top.sv
`timescale 1ns/100ps

module udp_stream_top import udp_pkg::*; (
    input  logic       s00_axi_aclk,
    input  logic       s00_axi_aresetn,
    // axi4-lite slave
    input  axil_addr_t s00_axi_awaddr,
    input  logic       s00_axi_awvalid,
    output logic       s00_axi_awready,
    input  reg_word_t  s00_axi_wdata,
    input  logic       s00_axi_wvalid,
    output logic       s00_axi_wready,
    output logic [1:0] s00_axi_bresp,
    output logic       s00_axi_bvalid,
    input  logic       s00_axi_bready,
    input  axil_addr_t s00_axi_araddr,
    input  logic       s00_axi_arvalid,
    output logic       s00_axi_arready,
    output reg_word_t  s00_axi_rdata,
    output logic [1:0] s00_axi_rresp,
    output logic       s00_axi_rvalid,
    input  logic       s00_axi_rready,
    // axi4-stream master
    output logic       m00_axis_tvalid,
    output beat_t      m00_axis_tdata,
    output keep_t      m00_axis_tkeep,
    output logic       m00_axis_tlast,
    input  logic       m00_axis_tready
);

    // configuration
    mac_t      dst_mac;
    ipv4_t     dst_ip;
    reg_word_t period;
    logic      period_wr;
    // timer and status
    reg_word_t timer;
    logic      send_pulse;
    reg_word_t sent_count;
    csum_t     ip_csum;
    // frame datapath
    beat_idx_t beat_idx;
    beat_t     beat;

    udp_axil_regs i_udp_axil_regs (
        .s00_axi_aclk    (s00_axi_aclk),
        .s00_axi_aresetn (s00_axi_aresetn),
        .s00_axi_awaddr  (s00_axi_awaddr),
        .s00_axi_awvalid (s00_axi_awvalid),
        .s00_axi_awready (s00_axi_awready),
        .s00_axi_wdata   (s00_axi_wdata),
        .s00_axi_wvalid  (s00_axi_wvalid),
        .s00_axi_wready  (s00_axi_wready),
        .s00_axi_bresp   (s00_axi_bresp),
        .s00_axi_bvalid  (s00_axi_bvalid),
        .s00_axi_bready  (s00_axi_bready),
        .s00_axi_araddr  (s00_axi_araddr),
        .s00_axi_arvalid (s00_axi_arvalid),
        .s00_axi_arready (s00_axi_arready),
        .s00_axi_rdata   (s00_axi_rdata),
        .s00_axi_rresp   (s00_axi_rresp),
        .s00_axi_rvalid  (s00_axi_rvalid),
        .s00_axi_rready  (s00_axi_rready),
        .timer           (timer),
        .sent_count      (sent_count),
        .ip_csum         (ip_csum),
        .dst_mac         (dst_mac),
        .dst_ip          (dst_ip),
        .period          (period),
        .period_wr       (period_wr)
    );

    udp_send_timer i_udp_send_timer (
        .s00_axi_aclk    (s00_axi_aclk),
        .s00_axi_aresetn (s00_axi_aresetn),
        .period          (period),
        .period_wr       (period_wr),
        .timer           (timer),
        .send_pulse      (send_pulse)
    );

    ip_header_checksum i_ip_header_checksum (
        .dst_ip  (dst_ip),
        .ip_csum (ip_csum)
    );

    udp_frame_assembler i_udp_frame_assembler (
        .beat_idx (beat_idx),
        .dst_mac  (dst_mac),
        .dst_ip   (dst_ip),
        .ip_csum  (ip_csum),
        .beat     (beat)
    );

    udp_stream_tx i_udp_stream_tx (
        .s00_axi_aclk    (s00_axi_aclk),
        .s00_axi_aresetn (s00_axi_aresetn),
        .send_pulse      (send_pulse),
        .beat            (beat),
        .m00_axis_tready (m00_axis_tready),
        .beat_idx        (beat_idx),
        .m00_axis_tvalid (m00_axis_tvalid),
        .m00_axis_tdata  (m00_axis_tdata),
        .m00_axis_tkeep  (m00_axis_tkeep),
        .m00_axis_tlast  (m00_axis_tlast),
        .sent_count      (sent_count)
    );

endmodule

// File: bench/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 16
) (
    output logic s00_axi_aclk,
    output logic s00_axi_aresetn
);

    // free-running clock
    initial begin
        s00_axi_aclk = 1'b0;
        forever #(PERIOD_NS / 2) s00_axi_aclk = ~s00_axi_aclk;
    end

    // reset held low for RESET_CYCLES rising edges, released on a falling edge
    initial begin
        s00_axi_aresetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge s00_axi_aclk);
        @(negedge s00_axi_aclk);
        s00_axi_aresetn = 1'b1;
    end

endmodule

// File: bench/udp_stream_tb.sv
`timescale 1ns/100ps
`include "udp_defines.svh"

module udp_stream_tb import udp_pkg::*; ();

    localparam int          CLK_NS       = 4;
    localparam int          RESET_CYCLES = 16;
    localparam int          HS_LIMIT     = 32;
    localparam reg_word_t   FAST_PERIOD  = 32'd40;
    localparam logic [31:0] SEED         = 32'h95c8_2e7d;

    typedef enum {OP_WRITE, OP_READ, OP_TREADY, OP_FRAME, OP_COUNT} op_t;

    typedef struct {
        op_t        op;
        axil_addr_t addr;
        reg_word_t  data;
        reg_word_t  exp;
    } test_t;

    logic       s00_axi_aclk;
    logic       s00_axi_aresetn;
    axil_addr_t s00_axi_awaddr;
    logic       s00_axi_awvalid;
    logic       s00_axi_awready;
    reg_word_t  s00_axi_wdata;
    logic       s00_axi_wvalid;
    logic       s00_axi_wready;
    logic [1:0] s00_axi_bresp;
    logic       s00_axi_bvalid;
    logic       s00_axi_bready;
    axil_addr_t s00_axi_araddr;
    logic       s00_axi_arvalid;
    logic       s00_axi_arready;
    reg_word_t  s00_axi_rdata;
    logic [1:0] s00_axi_rresp;
    logic       s00_axi_rvalid;
    logic       s00_axi_rready;
    logic       m00_axis_tvalid;
    beat_t      m00_axis_tdata;
    keep_t      m00_axis_tkeep;
    logic       m00_axis_tlast;
    logic       m00_axis_tready;

    test_t      tests[$];
    bit         table_ready  = 1'b0;
    bit         random_ready = 1'b0;
    int         err_count    = 0;
    int         pass_count   = 0;
    // model of the configuration as the table writes it
    mac_t       model_mac    = `UDP_DEFAULT_DST_MAC;
    ipv4_t      model_ip     = `UDP_DEFAULT_DST_IP;
    logic [7:0] exp_frame [`UDP_FRAME_BYTES];
    // monitor capture of the latest frame
    beat_t      cap_data [`UDP_FRAME_BEATS];
    keep_t      cap_keep [`UDP_FRAME_BEATS];
    logic       cap_last [`UDP_FRAME_BEATS];
    int         beat_cnt    = 0;
    int         cap_len     = 0;
    int         frames_seen = 0;
    // previous cycle values for the back-pressure hold check
    bit         stall_q     = 1'b0;
    beat_t      hold_data;
    keep_t      hold_keep;
    logic       hold_last;

    tb_clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(RESET_CYCLES)) i_tb_clock_gen (
        .s00_axi_aclk    (s00_axi_aclk),
        .s00_axi_aresetn (s00_axi_aresetn)
    );

    udp_stream_top i_udp_stream_top (.*);

    task automatic check_word(string name, reg_word_t got, reg_word_t exp);
        if (got !== exp) begin
            err_count++;
            $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic check_beat(string name, beat_t got, beat_t exp);
        if (got !== exp) begin
            err_count++;
            $display("** Error at %0t: %s = 0x%016h, expected 0x%016h", $time, name, got, exp);
        end
    endtask

    task automatic check_keep(string name, keep_t got, keep_t exp);
        if (got !== exp) begin
            err_count++;
            $display("** Error at %0t: %s = 0x%02h, expected 0x%02h", $time, name, got, exp);
        end
    endtask

    task automatic check_last(string name, logic got, logic exp);
        if (got !== exp) begin
            err_count++;
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_resp(string name, logic [1:0] got, logic [1:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    // 20 header bytes in wire order
    function automatic logic [159:0] ip_header(ipv4_t dst, csum_t cs);
        return {8'h45, 8'h00, 8'h00, 8'h49, 8'hE4, 8'h0F, 8'h40, 8'h00, 8'hFF, 8'h11,
                cs, 32'hC0A8_0401, dst};
    endfunction

    // ones' complement sum of ten words with the checksum field zeroed
    function automatic csum_t header_csum(ipv4_t dst);
        logic [159:0] hdr;
        logic [31:0]  acc;
        hdr = ip_header(dst, 16'h0000);
        acc = '0;
        for (int i = 0; i < 10; i++) begin
            acc = acc + {16'h0, hdr[159-16*i -: 16]};
        end
        while (acc[31:16] != 16'h0) begin
            acc = {16'h0, acc[15:0]} + {16'h0, acc[31:16]};
        end
        return ~acc[15:0];
    endfunction

    // expected 87 bytes from the byte map and the current model
    task automatic build_frame();
        logic [8*`UDP_FRAME_BYTES-1:0] f;
        f = {model_mac, 48'h001A_2B3C_4D5E, 16'h0800,
             ip_header(model_ip, header_csum(model_ip)),
             64'h14E9_14E9_0035_A5EB, `UDP_PAYLOAD};
        for (int i = 0; i < `UDP_FRAME_BYTES; i++) begin
            exp_frame[i] = f[8*`UDP_FRAME_BYTES-1-8*i -: 8];
        end
    endtask

    task automatic check_frame();
        beat_t exp_beat;
        int    idx;
        check_word("frame beat count", reg_word_t'(cap_len), reg_word_t'(`UDP_FRAME_BEATS));
        for (int b = 0; b < `UDP_FRAME_BEATS; b++) begin
            exp_beat = '0;
            // byte 7 of the last beat stays zero
            for (int k = 0; k < 8; k++) begin
                idx = 8 * b + k;
                if (idx < `UDP_FRAME_BYTES) begin
                    exp_beat[8*k +: 8] = exp_frame[idx];
                end
            end
            check_beat($sformatf("m00_axis_tdata beat %0d", b), cap_data[b], exp_beat);
            check_keep($sformatf("m00_axis_tkeep beat %0d", b), cap_keep[b],
                       (b == `UDP_FRAME_BEATS - 1) ? `UDP_LAST_KEEP : 8'hFF);
            check_last($sformatf("m00_axis_tlast beat %0d", b), cap_last[b],
                       b == `UDP_FRAME_BEATS - 1);
        end
    endtask

    task automatic axil_write(axil_addr_t addr, reg_word_t data);
        int n;
        @(negedge s00_axi_aclk);
        s00_axi_awaddr  = addr;
        s00_axi_wdata   = data;
        s00_axi_awvalid = 1'b1;
        s00_axi_wvalid  = 1'b1;
        s00_axi_bready  = 1'b1;
        n = 0;
        do begin
            @(posedge s00_axi_aclk);
            n++;
        end while (!(s00_axi_awready && s00_axi_wready) && n < HS_LIMIT);
        if (!(s00_axi_awready && s00_axi_wready)) begin
            err_count++;
            $display("write to 0x%02h was never accepted by awready and wready", addr);
        end
        @(negedge s00_axi_aclk);
        s00_axi_awvalid = 1'b0;
        s00_axi_wvalid  = 1'b0;
        n = 0;
        do begin
            @(posedge s00_axi_aclk);
            n++;
        end while (!s00_axi_bvalid && n < HS_LIMIT);
        if (!s00_axi_bvalid) begin
            err_count++;
            $display("write to 0x%02h got no write response", addr);
        end else begin
            check_resp("s00_axi_bresp", s00_axi_bresp, 2'b00);
        end
        @(negedge s00_axi_aclk);
        s00_axi_bready = 1'b0;
    endtask

    task automatic axil_read(axil_addr_t addr, output reg_word_t data);
        int n;
        @(negedge s00_axi_aclk);
        s00_axi_araddr  = addr;
        s00_axi_arvalid = 1'b1;
        s00_axi_rready  = 1'b1;
        n = 0;
        do begin
            @(posedge s00_axi_aclk);
            n++;
        end while (!s00_axi_arready && n < HS_LIMIT);
        @(negedge s00_axi_aclk);
        s00_axi_arvalid = 1'b0;
        n = 0;
        do begin
            @(posedge s00_axi_aclk);
            n++;
        end while (!s00_axi_rvalid && n < HS_LIMIT);
        if (!s00_axi_rvalid) begin
            err_count++;
            $display("read from 0x%02h returned no data", addr);
        end else begin
            check_resp("s00_axi_rresp", s00_axi_rresp, 2'b00);
        end
        data = s00_axi_rdata;
        @(negedge s00_axi_aclk);
        s00_axi_rready = 1'b0;
    endtask

    task automatic wait_frames(int target);
        while (frames_seen < target) begin
            @(negedge s00_axi_aclk);
        end
    endtask

    task automatic add(op_t op, axil_addr_t addr, reg_word_t data, reg_word_t exp);
        tests.push_back('{op, addr, data, exp});
    endtask

    task automatic build_table();
        logic [7:0] mac_new [6];
        ipv4_t      ip_a;
        ipv4_t      ip_b;
        mac_new = '{8'h02, 8'h11, 8'h22, 8'h33, 8'h44, 8'h55};
        ip_a = 32'hC0A8_0463;
        ip_b = 32'hFFFF_FF00;
        // reset values
        add(OP_READ, `REG_SENT_COUNT, '0, '0);
        for (int m = 0; m < 6; m++) begin
            add(OP_READ, `REG_DST_MAC0 + 6'(4 * m), '0, 32'h0000_00FF);
        end
        add(OP_READ, `REG_DST_IP, '0, `UDP_DEFAULT_DST_IP);
        add(OP_READ, `REG_PERIOD, '0, `UDP_DEFAULT_PERIOD);
        add(OP_READ, `REG_IP_CHECKSUM, '0, {16'h0, header_csum(`UDP_DEFAULT_DST_IP)});
        // mac bytes keep only the low byte of the write
        for (int m = 0; m < 6; m++) begin
            add(OP_WRITE, `REG_DST_MAC0 + 6'(4 * m), {24'hA5A5A5, mac_new[m]}, '0);
        end
        for (int m = 0; m < 6; m++) begin
            add(OP_READ, `REG_DST_MAC0 + 6'(4 * m), '0, {24'h0, mac_new[m]});
        end
        add(OP_WRITE, `REG_DST_IP, ip_a, '0);
        add(OP_READ, `REG_DST_IP, '0, ip_a);
        add(OP_READ, `REG_IP_CHECKSUM, '0, {16'h0, header_csum(ip_a)});
        // read-only and unmapped offsets
        add(OP_WRITE, `REG_SENT_COUNT, 32'h0000_1234, '0);
        add(OP_READ, `REG_SENT_COUNT, '0, '0);
        add(OP_WRITE, `REG_IP_CHECKSUM, 32'h0000_FFFF, '0);
        add(OP_READ, `REG_IP_CHECKSUM, '0, {16'h0, header_csum(ip_a)});
        add(OP_WRITE, 6'h30, 32'hDEAD_BEEF, '0);
        add(OP_READ, 6'h30, '0, '0);
        add(OP_READ, 6'h3C, '0, '0);
        // frames with tready held high
        add(OP_WRITE, `REG_PERIOD, FAST_PERIOD, '0);
        add(OP_READ, `REG_PERIOD, '0, FAST_PERIOD);
        add(OP_TREADY, '0, 32'd0, '0);
        add(OP_FRAME, '0, '0, '0);
        add(OP_COUNT, `REG_SENT_COUNT, '0, '0);
        // carry-heavy address changed while frames run
        add(OP_WRITE, `REG_DST_IP, ip_b, '0);
        add(OP_READ, `REG_IP_CHECKSUM, '0, {16'h0, header_csum(ip_b)});
        add(OP_WRITE, `REG_DST_MAC2, 32'h0000_009A, '0);
        add(OP_FRAME, '0, '0, '0);
        // random back-pressure
        add(OP_TREADY, '0, 32'd1, '0);
        add(OP_FRAME, '0, '0, '0);
        add(OP_FRAME, '0, '0, '0);
        add(OP_COUNT, `REG_SENT_COUNT, '0, '0);
    endtask

    // tready driven on the falling edge and random only when enabled
    always @(negedge s00_axi_aclk) begin
        m00_axis_tready = random_ready ? (($urandom() & 32'h1) != 0) : 1'b1;
    end

    // stream monitor sampling on the rising edge
    always @(posedge s00_axi_aclk) begin
        // a stalled beat must not change
        if (stall_q) begin
            check_beat("m00_axis_tdata while stalled", m00_axis_tdata, hold_data);
            check_keep("m00_axis_tkeep while stalled", m00_axis_tkeep, hold_keep);
            check_last("m00_axis_tlast while stalled", m00_axis_tlast, hold_last);
        end
        stall_q   = m00_axis_tvalid && !m00_axis_tready;
        hold_data = m00_axis_tdata;
        hold_keep = m00_axis_tkeep;
        hold_last = m00_axis_tlast;
        if (m00_axis_tvalid && m00_axis_tready) begin
            if (beat_cnt < `UDP_FRAME_BEATS) begin
                cap_data[beat_cnt] = m00_axis_tdata;
                cap_keep[beat_cnt] = m00_axis_tkeep;
                cap_last[beat_cnt] = m00_axis_tlast;
            end
            beat_cnt++;
            if (m00_axis_tlast) begin
                cap_len  = beat_cnt;
                beat_cnt = 0;
                frames_seen++;
            end else if (beat_cnt == `UDP_FRAME_BEATS + 1) begin
                err_count++;
                $display("frame ran past %0d beats without tlast", `UDP_FRAME_BEATS);
            end
        end
    end

    // budget per table entry scales with the programmed period
    initial begin
        longint limit_ns;
        wait (table_ready);
        limit_ns = (longint'(tests.size()) * (longint'(FAST_PERIOD) + 64) + RESET_CYCLES)
                   * CLK_NS;
        #(limit_ns);
        $display("timeout: the test table did not finish within %0d ns", limit_ns);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        test_t     t;
        reg_word_t rd;
        int        errs_before;
        void'($urandom(SEED));
        s00_axi_awaddr  = '0;
        s00_axi_awvalid = 1'b0;
        s00_axi_wdata   = '0;
        s00_axi_wvalid  = 1'b0;
        s00_axi_bready  = 1'b0;
        s00_axi_araddr  = '0;
        s00_axi_arvalid = 1'b0;
        s00_axi_rready  = 1'b0;
        m00_axis_tready = 1'b1;
        build_table();
        table_ready = 1'b1;
        wait (s00_axi_aresetn);
        @(negedge s00_axi_aclk);
        foreach (tests[i]) begin
            t = tests[i];
            errs_before = err_count;
            case (t.op)
                OP_WRITE: begin
                    axil_write(t.addr, t.data);
                    if (t.addr == `REG_DST_IP) begin
                        model_ip = t.data;
                    end
                    for (int m = 0; m < 6; m++) begin
                        if (t.addr == `REG_DST_MAC0 + 6'(4 * m)) begin
                            model_mac[47-8*m -: 8] = t.data[7:0];
                        end
                    end
                end
                OP_READ: begin
                    axil_read(t.addr, rd);
                    check_word($sformatf("s00_axi_rdata at 0x%02h", t.addr), rd, t.exp);
                end
                OP_TREADY: random_ready = t.data[0];
                OP_FRAME: begin
                    // second frame starts after any config change
                    wait_frames(frames_seen + 2);
                    build_frame();
                    check_frame();
                end
                OP_COUNT: begin
                    // read right after a frame ends while the stream is idle
                    wait_frames(frames_seen + 1);
                    axil_read(t.addr, rd);
                    check_word("sent_count", rd, reg_word_t'(frames_seen));
                end
                default: ;
            endcase
            if (err_count == errs_before) begin
                pass_count++;
            end
            $display("test %0d %s addr 0x%02h: %s", i, t.op.name(), t.addr,
                     (err_count == errs_before) ? "ok" : "FAILED");
        end
        $display("tests passed %0d of %0d, errors %0d", pass_count, tests.size(), err_count);
        if (err_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+hw
hw/udp_pkg.sv
hw/udp_axil_regs.sv
hw/udp_send_timer.sv
hw/ip_header_checksum.sv
hw/udp_frame_assembler.sv
hw/udp_stream_tx.sv
hw/udp_stream_top.sv
bench/tb_clock_gen.sv
bench/udp_stream_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the udp stream testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
    --top-module udp_stream_tb -f project.f -o udp_stream_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/udp_stream_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -qx "Simulation passed" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL, see sim.log"
    exit 1
fi
